//--- files.f
hw/cpu_types_pkg.sv
hw/datapath_cache_if.sv
hw/caches_if.sv
hw/dcache_sets.sv
hw/dcache.sv
hw/dcache_top.sv
verif/tb_clock.sv
verif/tb_mem_model.sv
verif/dcache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --top-module dcache_tb -f files.f \
    -Mdir obj_dir -o dcache_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/dcache_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "Test OK" "$SIM_LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0

//--- verif/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import cpu_types_pkg::*;

    localparam int NUM_SETS    = 1 << DIDX_W;
    localparam int NUM_RANDOM  = 40;
    localparam int MAX_LAT     = 3;
    // worst request is a dirty miss, worst flush writes every frame
    localparam int MISS_CYCLES = 4 + 4 * (MAX_LAT + 1);
    localparam int FLUSH_CYC   = 2 * NUM_SETS * (2 * (MAX_LAT + 1) + 1) + MAX_LAT + 4;
    localparam int LIMIT_CYCLES = 2 * ((16 + NUM_RANDOM) * MISS_CYCLES + FLUSH_CYC + 40);

    typedef struct packed {
        logic  wr;
        word_t addr;
        word_t data;
    } mem_op_t;

    logic  CLK, nRST;
    logic  halt, ihit, dmemREN, dmemWEN, dhit, flushed;
    word_t dmemaddr, dmemstore, dmemload;
    logic  dREN, dWEN, dwait;
    word_t daddr, dstore, dload, peek_addr, peek_data;
    int    mem_lat;

    // shadow cache and memory
    logic              sh_valid [2][NUM_SETS];
    logic              sh_dirty [2][NUM_SETS];
    logic [DTAG_W-1:0] sh_tag   [2][NUM_SETS];
    word_t             sh_data  [2][NUM_SETS][2];
    logic [NUM_SETS-1:0] sh_lru;
    word_t             sh_mem   [logic [29:0]];
    int                sh_hits;
    mem_op_t           exp_q [$];

    int          errors, checks, base_errs, mon_errs, mon_checks, mon_pos, stall_errs;
    logic        last_dut_hit;
    logic [15:0] lfsr_q;

    tb_clock #(.PERIOD(20), .RST_CYCLES(8)) u_clock (.CLK(CLK), .nRST(nRST));

    tb_mem_model u_mem (
        .CLK(CLK), .nRST(nRST), .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
        .latency(mem_lat), .dwait(dwait), .dload(dload),
        .peek_addr(peek_addr), .peek_data(peek_data)
    );

    dcache_top UUT (
        .CLK(CLK), .nRST(nRST), .halt(halt), .ihit(ihit),
        .dmemREN(dmemREN), .dmemWEN(dmemWEN), .dmemaddr(dmemaddr), .dmemstore(dmemstore),
        .dhit(dhit), .dmemload(dmemload), .flushed(flushed),
        .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
        .dwait(dwait), .dload(dload)
    );

    req_held_under_dwait: assert property (@(posedge CLK) disable iff (!nRST)
            ((dREN || dWEN) && dwait) |=> ($stable(dREN) && $stable(dWEN)
                                           && $stable(daddr) && $stable(dstore)))
        else begin
            stall_errs++;
            $display("memory request changed while dwait was high, daddr now %h", daddr);
        end

    // memory traffic checked against the shadow model's expected transfers
    always @(negedge CLK) begin
        if (nRST) begin
            mon_checks++;
            assert (!(dREN && dWEN)) else begin
                mon_errs++;
                $display("dREN and dWEN were high in the same cycle");
            end
            assert (!dhit || dmemREN || dmemWEN) else begin
                mon_errs++;
                $display("dhit was high without a request");
            end
            if ((dREN || dWEN) && !dwait) begin
                if (mon_pos >= exp_q.size()) begin
                    mon_errs++;
                    $display("unexpected memory %s at %h", dWEN ? "write" : "read", daddr);
                end else begin
                    assert (dWEN == exp_q[mon_pos].wr) else begin
                        mon_errs++;
                        $display("[FAIL] dWEN expected %h got %h", exp_q[mon_pos].wr, dWEN);
                    end
                    assert (daddr == exp_q[mon_pos].addr) else begin
                        mon_errs++;
                        $display("[FAIL] daddr expected %h got %h", exp_q[mon_pos].addr, daddr);
                    end
                    assert (!dWEN || dstore == exp_q[mon_pos].data) else begin
                        mon_errs++;
                        $display("[FAIL] dstore expected %h got %h", exp_q[mon_pos].data, dstore);
                    end
                    mon_pos++;
                end
            end
        end
    end

    function automatic word_t lfsr_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic word_t make_addr(input logic [DTAG_W-1:0] tag,
                                        input logic [DIDX_W-1:0] idx, input logic w);
        return {tag, idx, w, 2'b00};
    endfunction

    function automatic word_t model_word(input word_t a);
        if (sh_mem.exists(a[31:2])) begin
            return sh_mem[a[31:2]];
        end
        return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic int total_errors();
        return errors + mon_errs + stall_errs;
    endfunction

    task automatic expect_word(input string name, input word_t exp, input word_t got);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic queue_mem_op(input logic wr, input word_t addr, input word_t data);
        mem_op_t op;
        op.wr   = wr;
        op.addr = addr;
        op.data = data;
        exp_q.push_back(op);
        if (wr) begin
            sh_mem[addr[31:2]] = data;
        end
    endtask

    // lookup, victim write-back and refill by the cache's rules
    task automatic model_access(input logic wr, input word_t addr, input word_t wdata,
                                output word_t load, output logic hit);
        dcachef_t f;
        logic     way;
        f   = addr;
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (sh_valid[w][f.idx] && sh_tag[w][f.idx] == f.tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (hit) begin
            sh_hits++;
        end else begin
            way = sh_lru[f.idx];
            if (sh_valid[way][f.idx] && sh_dirty[way][f.idx]) begin
                for (int b = 0; b < 2; b++) begin
                    queue_mem_op(1'b1, make_addr(sh_tag[way][f.idx], f.idx, 1'(b)),
                                 sh_data[way][f.idx][b]);
                end
            end
            for (int b = 0; b < 2; b++) begin
                queue_mem_op(1'b0, make_addr(f.tag, f.idx, 1'(b)), '0);
                sh_data[way][f.idx][b] = model_word(make_addr(f.tag, f.idx, 1'(b)));
            end
            sh_valid[way][f.idx] = 1'b1;
            sh_dirty[way][f.idx] = 1'b0;
            sh_tag[way][f.idx]   = f.tag;
        end
        sh_lru[f.idx] = ~way;
        if (wr) begin
            sh_data[way][f.idx][f.blkoff] = wdata;
            sh_dirty[way][f.idx] = 1'b1;
            load = wdata;
        end else begin
            load = sh_data[way][f.idx][f.blkoff];
        end
    endtask

    task automatic issue_request(input logic wr, input word_t addr, input word_t wdata);
        word_t exp_load;
        logic  model_hit;
        int    cycles;
        model_access(wr, addr, wdata, exp_load, model_hit);
        @(posedge CLK);
        dmemREN   <= ~wr;
        dmemWEN   <= wr;
        dmemaddr  <= addr;
        dmemstore <= wdata;
        ihit      <= 1'b1;
        cycles = 0;
        do begin
            @(negedge CLK);
            cycles++;
        end while (!dhit);
        last_dut_hit = (cycles == 1);
        expect_word("dmemload", exp_load, dmemload);
        expect_true(last_dut_hit == model_hit,
                    $sformatf("access to %h hit/miss timing wrong after %0d cycles", addr, cycles));
        expect_true(mon_pos == exp_q.size(), "memory transfers of a request were missing");
        @(posedge CLK);
        dmemREN <= 1'b0;
        dmemWEN <= 1'b0;
        ihit    <= 1'b0;
    endtask

    task automatic expect_mem_word(input word_t addr, input word_t exp);
        peek_addr = addr;
        #1;
        expect_word($sformatf("mem[%h]", addr), exp, peek_data);
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %-18s %0d errors", num, name, total_errors() - base_errs);
        base_errs = total_errors();
    endtask

    initial begin : watchdog
        repeat (LIMIT_CYCLES) @(posedge CLK);
        $display("watchdog expired after %0d cycles", LIMIT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        halt      <= 1'b0;
        ihit      <= 1'b0;
        dmemREN   <= 1'b0;
        dmemWEN   <= 1'b0;
        dmemaddr  <= '0;
        dmemstore <= '0;
        mem_lat   <= 2;
        peek_addr = '0;
        lfsr_q    = 16'd41867;
        sh_lru    = '0;
        sh_hits   = 0;
        errors    = 0;
        checks    = 0;
        base_errs = 0;
        mon_errs  = 0;
        mon_checks = 0;
        mon_pos   = 0;
        stall_errs = 0;
        for (int w = 0; w < 2; w++) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                sh_valid[w][i] = 1'b0;
                sh_dirty[w][i] = 1'b0;
            end
        end

        wait (nRST === 1'b1);
        @(negedge CLK);
        expect_true(!dREN && !dWEN && !dhit && !flushed, "outputs not idle after reset");
        issue_request(1'b0, make_addr(26'h40, 3'd1, 1'b0), '0);
        report_test(1, "reset, read miss");

        issue_request(1'b0, make_addr(26'h40, 3'd1, 1'b0), '0);
        issue_request(1'b0, make_addr(26'h40, 3'd1, 1'b1), '0);
        issue_request(1'b1, make_addr(26'h40, 3'd1, 1'b1), 32'hc0ff_ee01);
        issue_request(1'b0, make_addr(26'h40, 3'd1, 1'b1), '0);
        expect_true(last_dut_hit, "load after store hit did not hit");
        report_test(2, "hits");

        // way 0 touched last, so the third tag takes way 1
        issue_request(1'b0, make_addr(26'h100, 3'd2, 1'b0), '0);
        issue_request(1'b0, make_addr(26'h200, 3'd2, 1'b0), '0);
        issue_request(1'b0, make_addr(26'h100, 3'd2, 1'b1), '0);
        issue_request(1'b0, make_addr(26'h300, 3'd2, 1'b0), '0);
        issue_request(1'b0, make_addr(26'h100, 3'd2, 1'b0), '0);
        expect_true(last_dut_hit, "block kept in way 0 was lost");
        issue_request(1'b0, make_addr(26'h200, 3'd2, 1'b1), '0);
        expect_true(!last_dut_hit, "evicted block still hit");
        report_test(3, "lru replacement");

        issue_request(1'b1, make_addr(26'h110, 3'd3, 1'b0), 32'h1357_9bdf);
        issue_request(1'b1, make_addr(26'h110, 3'd3, 1'b1), 32'h2468_ace0);
        issue_request(1'b0, make_addr(26'h220, 3'd3, 1'b0), '0);
        issue_request(1'b0, make_addr(26'h330, 3'd3, 1'b1), '0);
        expect_mem_word(make_addr(26'h110, 3'd3, 1'b0), 32'h1357_9bdf);
        expect_mem_word(make_addr(26'h110, 3'd3, 1'b1), 32'h2468_ace0);
        report_test(4, "dirty write-back");

        for (int n = 0; n < NUM_RANDOM; n++) begin
            logic              wr;
            logic [DTAG_W-1:0] tag;
            logic [DIDX_W-1:0] idx;
            logic              w;
            word_t             data;
            mem_lat <= int'(lfsr_bits(2));
            wr   = 1'(lfsr_bits(1));
            tag  = 26'h400 | DTAG_W'(lfsr_bits(2));
            idx  = DIDX_W'(lfsr_bits(DIDX_W));
            w    = 1'(lfsr_bits(1));
            data = lfsr_bits(32);
            issue_request(wr, make_addr(tag, idx, w), data);
        end
        mem_lat <= 2;
        report_test(5, "back-pressure mix");

        // way 0 in index order, then way 1, then the hit count
        for (int w = 0; w < 2; w++) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                if (sh_valid[w][i] && sh_dirty[w][i]) begin
                    for (int b = 0; b < 2; b++) begin
                        queue_mem_op(1'b1, make_addr(sh_tag[w][i], DIDX_W'(i), 1'(b)),
                                     sh_data[w][i][b]);
                    end
                    sh_dirty[w][i] = 1'b0;
                end
            end
        end
        queue_mem_op(1'b1, STATS_ADDR, sh_hits);
        @(posedge CLK);
        halt <= 1'b1;
        do begin
            @(negedge CLK);
        end while (!flushed);
        expect_true(dWEN && !dwait && daddr == STATS_ADDR,
                    "flushed rose outside the statistics write");
        @(negedge CLK);
        expect_true(flushed, "flushed dropped while halt was held");
        expect_true(mon_pos == exp_q.size(), "flush left expected writes undone");
        @(posedge CLK);
        halt <= 1'b0;
        foreach (sh_mem[k]) begin
            expect_mem_word({k, 2'b00}, sh_mem[k]);
        end
        report_test(6, "flush");

        $display("checks %0d, bus checks %0d, errors %0d", checks, mon_checks, total_errors());
        if (total_errors() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  dREN,
    input  logic                  dWEN,
    input  cpu_types_pkg::word_t  daddr,
    input  cpu_types_pkg::word_t  dstore,
    input  int                    latency,
    output logic                  dwait,
    output cpu_types_pkg::word_t  dload,
    input  cpu_types_pkg::word_t  peek_addr,
    output cpu_types_pkg::word_t  peek_data
);
    import cpu_types_pkg::*;

    // sparse word store whose unwritten words follow a pattern of the address
    word_t mem [logic [29:0]];
    int    cnt;

    function automatic word_t read_word(input word_t a);
        if (mem.exists(a[31:2])) begin
            return mem[a[31:2]];
        end
        return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    assign dwait = (dREN || dWEN) && (cnt < latency);

    always_comb begin
        dload     = read_word(daddr);
        peek_data = read_word(peek_addr);
    end

    // wait cycles of the current word
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cnt <= 0;
        end else if ((dREN || dWEN) && dwait) begin
            cnt <= cnt + 1;
        end else begin
            cnt <= 0;
        end
    end

    always @(posedge CLK) begin
        if (nRST && dWEN && !dwait) begin
            mem[daddr[31:2]] = dstore;
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 8
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // reset released on a rising edge
    initial begin
        nRST = 1'b0;
        repeat (RST_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

`default_nettype wire

//--- hw/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int SETS = 8
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  halt,
    input  logic                  ihit,
    input  logic                  dmemREN,
    input  logic                  dmemWEN,
    input  cpu_types_pkg::word_t  dmemaddr,
    input  cpu_types_pkg::word_t  dmemstore,
    output logic                  dhit,
    output cpu_types_pkg::word_t  dmemload,
    output logic                  flushed,
    output logic                  dREN,
    output logic                  dWEN,
    output cpu_types_pkg::word_t  daddr,
    output cpu_types_pkg::word_t  dstore,
    input  logic                  dwait,
    input  cpu_types_pkg::word_t  dload
);
    import cpu_types_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = 32 - IDX_W - 3;

    datapath_cache_if dcif ();
    caches_if         cif ();

    // frame store control
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] req_tag;
    logic [TAG_W-1:0] fill_tag;
    logic             hit0, hit1, lru_way, sel_way;
    logic             fill_en, fill_sel;
    logic             store_en, store_way, store_off;
    logic             clean_en, touch_en, touch_way;
    dcache_frame      frame_out;
    word_t            fill_word;
    word_t            store_data;

    // datapath side from plain ports
    assign dcif.halt      = halt;
    assign dcif.ihit      = ihit;
    assign dcif.dmemREN   = dmemREN;
    assign dcif.dmemWEN   = dmemWEN;
    assign dcif.dmemaddr  = dmemaddr;
    assign dcif.dmemstore = dmemstore;
    assign dhit           = dcif.dhit;
    assign dmemload       = dcif.dmemload;
    assign flushed        = dcif.flushed;

    // memory side
    assign dREN      = cif.dREN;
    assign dWEN      = cif.dWEN;
    assign daddr     = cif.daddr;
    assign dstore    = cif.dstore;
    assign cif.dwait = dwait;
    assign cif.dload = dload;

    dcache #(
        .SETS(SETS)
    ) u_dcache (
        .CLK        (CLK),
        .nRST       (nRST),
        .dcif       (dcif.cache),
        .cif        (cif.dcache),
        .idx        (idx),
        .req_tag    (req_tag),
        .hit0       (hit0),
        .hit1       (hit1),
        .lru_way    (lru_way),
        .sel_way    (sel_way),
        .frame_out  (frame_out),
        .fill_en    (fill_en),
        .fill_word  (fill_word),
        .fill_sel   (fill_sel),
        .fill_tag   (fill_tag),
        .store_en   (store_en),
        .store_way  (store_way),
        .store_off  (store_off),
        .store_data (store_data),
        .clean_en   (clean_en),
        .touch_en   (touch_en),
        .touch_way  (touch_way)
    );

    dcache_sets #(
        .SETS(SETS)
    ) u_sets (
        .CLK        (CLK),
        .nRST       (nRST),
        .idx        (idx),
        .req_tag    (req_tag),
        .hit0       (hit0),
        .hit1       (hit1),
        .lru_way    (lru_way),
        .sel_way    (sel_way),
        .frame_out  (frame_out),
        .fill_en    (fill_en),
        .fill_word  (fill_word),
        .fill_sel   (fill_sel),
        .fill_tag   (fill_tag),
        .store_en   (store_en),
        .store_way  (store_way),
        .store_off  (store_off),
        .store_data (store_data),
        .clean_en   (clean_en),
        .touch_en   (touch_en),
        .touch_way  (touch_way)
    );

endmodule

`default_nettype wire

//--- hw/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache #(
    parameter int SETS = 8,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = 32 - IDX_W - 3
) (
    input  logic                        CLK,
    input  logic                        nRST,
    datapath_cache_if.cache             dcif,
    caches_if.dcache                    cif,
    output logic [IDX_W-1:0]            idx,
    output logic [TAG_W-1:0]            req_tag,
    input  logic                        hit0,
    input  logic                        hit1,
    input  logic                        lru_way,
    output logic                        sel_way,
    input  cpu_types_pkg::dcache_frame  frame_out,
    output logic                        fill_en,
    output cpu_types_pkg::word_t        fill_word,
    output logic                        fill_sel,
    output logic [TAG_W-1:0]            fill_tag,
    output logic                        store_en,
    output logic                        store_way,
    output logic                        store_off,
    output cpu_types_pkg::word_t        store_data,
    output logic                        clean_en,
    output logic                        touch_en,
    output logic                        touch_way
);
    import cpu_types_pkg::*;

    typedef enum logic [3:0] {
        COMPARE,
        WB1,
        WB2,
        ALLOC1,
        ALLOC2,
        FLUSH,
        FLUSH_WB2,
        STATS,
        DONE
    } state_t;

    state_t           state, next_state;
    dcachef_t         req;
    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] victim_tag;
    logic             flushing;

    // flush walk counter with the way in its msb
    logic [IDX_W:0]   fl_cnt, next_fl_cnt;

    word_t            hit_count, next_hit_count;
    logic             fill_hit, next_fill_hit;

    assign req     = dcif.dmemaddr;
    assign req_tag = dcif.dmemaddr[31 -: TAG_W];
    assign req_idx = dcif.dmemaddr[IDX_W+2:3];

    assign flushing = (state == FLUSH) || (state == FLUSH_WB2);
    assign idx      = flushing ? fl_cnt[IDX_W-1:0] : req_idx;

    // hit way during compare, victim otherwise
    always_comb begin
        if (flushing) begin
            sel_way = fl_cnt[IDX_W];
        end else if (state == COMPARE) begin
            sel_way = ~hit0 & (hit1 | lru_way);
        end else begin
            sel_way = lru_way;
        end
    end

    assign victim_tag = TAG_W'(frame_out.tag);

    assign fill_word  = cif.dload;
    assign fill_tag   = req_tag;
    assign store_way  = hit1;
    assign store_off  = req.blkoff;
    assign store_data = dcif.dmemstore;
    assign touch_way  = sel_way;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= COMPARE;
            fl_cnt     <= '0;
            hit_count  <= '0;
            fill_hit   <= 1'b0;
        end else begin
            state      <= next_state;
            fl_cnt     <= next_fl_cnt;
            hit_count  <= next_hit_count;
            fill_hit   <= next_fill_hit;
        end
    end

    always_comb begin
        next_state      = state;
        next_fl_cnt     = fl_cnt;
        next_hit_count  = hit_count;
        next_fill_hit   = fill_hit;

        dcif.dhit     = 1'b0;
        dcif.dmemload = '0;
        dcif.flushed  = 1'b0;
        cif.dREN      = 1'b0;
        cif.dWEN      = 1'b0;
        cif.daddr     = '0;
        cif.dstore    = '0;
        fill_en       = 1'b0;
        fill_sel      = 1'b0;
        store_en      = 1'b0;
        clean_en      = 1'b0;
        touch_en      = 1'b0;

        case (state)
            COMPARE: begin
                if (dcif.halt) begin
                    next_state  = FLUSH;
                    next_fl_cnt = '0;
                end else if (dcif.dmemREN || dcif.dmemWEN) begin
                    if (hit0 || hit1) begin
                        dcif.dhit     = 1'b1;
                        dcif.dmemload = dcif.dmemWEN ? dcif.dmemstore
                                                     : frame_out.data[req.blkoff];
                        store_en      = dcif.dmemWEN;
                        touch_en      = 1'b1;
                        // the hit right after a fill was already a miss
                        if (dcif.ihit) begin
                            if (fill_hit) begin
                                next_fill_hit = 1'b0;
                            end else begin
                                next_hit_count = hit_count + 1;
                            end
                        end
                    end else begin
                        next_state = frame_out.dirty ? WB1 : ALLOC1;
                    end
                end
            end

            WB1: begin
                cif.dWEN   = 1'b1;
                cif.daddr  = {victim_tag, idx, 1'b0, 2'b00};
                cif.dstore = frame_out.data[0];
                if (!cif.dwait) begin
                    next_state = WB2;
                end
            end

            WB2: begin
                cif.dWEN   = 1'b1;
                cif.daddr  = {victim_tag, idx, 1'b1, 2'b00};
                cif.dstore = frame_out.data[1];
                if (!cif.dwait) begin
                    clean_en   = 1'b1;
                    next_state = ALLOC1;
                end
            end

            ALLOC1: begin
                cif.dREN  = 1'b1;
                cif.daddr = {req_tag, idx, 1'b0, 2'b00};
                if (!cif.dwait) begin
                    fill_en    = 1'b1;
                    next_state = ALLOC2;
                end
            end

            ALLOC2: begin
                cif.dREN  = 1'b1;
                cif.daddr = {req_tag, idx, 1'b1, 2'b00};
                if (!cif.dwait) begin
                    fill_en         = 1'b1;
                    fill_sel        = 1'b1;
                    touch_en        = 1'b1;
                    next_fill_hit   = 1'b1;
                    next_state      = COMPARE;
                end
            end

            // clean frames cost one cycle, dirty ones start writing at once
            FLUSH: begin
                if (frame_out.dirty) begin
                    cif.dWEN   = 1'b1;
                    cif.daddr  = {victim_tag, idx, 1'b0, 2'b00};
                    cif.dstore = frame_out.data[0];
                    if (!cif.dwait) begin
                        next_state = FLUSH_WB2;
                    end
                end else begin
                    next_fl_cnt = fl_cnt + 1'b1;
                    if (&fl_cnt) begin
                        next_state = STATS;
                    end
                end
            end

            FLUSH_WB2: begin
                cif.dWEN   = 1'b1;
                cif.daddr  = {victim_tag, idx, 1'b1, 2'b00};
                cif.dstore = frame_out.data[1];
                if (!cif.dwait) begin
                    clean_en    = 1'b1;
                    next_fl_cnt = fl_cnt + 1'b1;
                    next_state  = (&fl_cnt) ? STATS : FLUSH;
                end
            end

            STATS: begin
                cif.dWEN   = 1'b1;
                cif.daddr  = STATS_ADDR;
                cif.dstore = hit_count;
                if (!cif.dwait) begin
                    dcif.flushed = 1'b1;
                    next_state   = DONE;
                end
            end

            DONE: begin
                dcif.flushed = dcif.halt;
                if (!dcif.halt) begin
                    next_state = COMPARE;
                end
            end

            default: begin
                next_state = COMPARE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/dcache_sets.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_sets #(
    parameter int SETS = 8,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = 32 - IDX_W - 3
) (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic [IDX_W-1:0]            idx,
    input  logic [TAG_W-1:0]            req_tag,
    output logic                        hit0,
    output logic                        hit1,
    output logic                        lru_way,
    input  logic                        sel_way,
    output cpu_types_pkg::dcache_frame  frame_out,
    input  logic                        fill_en,
    input  cpu_types_pkg::word_t        fill_word,
    input  logic                        fill_sel,
    input  logic [TAG_W-1:0]            fill_tag,
    input  logic                        store_en,
    input  logic                        store_way,
    input  logic                        store_off,
    input  cpu_types_pkg::word_t        store_data,
    input  logic                        clean_en,
    input  logic                        touch_en,
    input  logic                        touch_way
);
    import cpu_types_pkg::*;

    // status bits per way and index
    logic [1:0][SETS-1:0] valid;
    logic [1:0][SETS-1:0] dirty;
    logic [SETS-1:0]      lru;

    // payload storage
    logic [TAG_W-1:0] tags [2][SETS];
    word_t            data [2][SETS][DBLK_WORDS];

    assign hit0    = valid[0][idx] && (tags[0][idx] == req_tag);
    assign hit1    = valid[1][idx] && (tags[1][idx] == req_tag);
    assign lru_way = lru[idx];

    always_comb begin
        frame_out.valid = valid[sel_way][idx];
        frame_out.dirty = dirty[sel_way][idx];
        frame_out.tag   = DTAG_W'(tags[sel_way][idx]);
        for (int w = 0; w < DBLK_WORDS; w++) begin
            frame_out.data[w] = data[sel_way][idx][w];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            // second fill word completes the block
            if (fill_en && fill_sel) begin
                valid[sel_way][idx] <= 1'b1;
                dirty[sel_way][idx] <= 1'b0;
            end
            if (store_en) begin
                dirty[store_way][idx] <= 1'b1;
            end
            if (clean_en) begin
                dirty[sel_way][idx] <= 1'b0;
            end
            // lru names the way not used last
            if (touch_en) begin
                lru[idx] <= ~touch_way;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_en) begin
            data[sel_way][idx][fill_sel] <= fill_word;
            if (fill_sel) begin
                tags[sel_way][idx] <= fill_tag;
            end
        end
        if (store_en) begin
            data[store_way][idx][store_off] <= store_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/caches_if.sv
`timescale 1ns/1ps
`default_nettype none

interface caches_if;
    import cpu_types_pkg::*;

    // requests from the data cache, held while dwait is high
    logic  dREN;
    logic  dWEN;
    word_t daddr;
    word_t dstore;

    // memory response
    logic  dwait;
    word_t dload;

    modport dcache (
        output dREN, dWEN, daddr, dstore,
        input  dwait, dload
    );

    modport mem (
        input  dREN, dWEN, daddr, dstore,
        output dwait, dload
    );

endinterface

`default_nettype wire

//--- hw/datapath_cache_if.sv
`timescale 1ns/1ps
`default_nettype none

interface datapath_cache_if;
    import cpu_types_pkg::*;

    // datapath side
    logic  halt;
    logic  ihit;
    logic  dmemREN;
    logic  dmemWEN;
    word_t dmemaddr;
    word_t dmemstore;

    // cache side
    logic  dhit;
    word_t dmemload;
    logic  flushed;

    modport cache (
        input  halt, ihit, dmemREN, dmemWEN, dmemaddr, dmemstore,
        output dhit, dmemload, flushed
    );

    modport datapath (
        output halt, ihit, dmemREN, dmemWEN, dmemaddr, dmemstore,
        input  dhit, dmemload, flushed
    );

endinterface

`default_nettype wire

//--- hw/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

    localparam int WORD_W = 32;

    // address split for the default of 8 indices
    localparam int DTAG_W = 26;
    localparam int DIDX_W = 3;
    localparam int DBLK_W = 1;
    localparam int DBYT_W = 2;

    localparam int DBLK_WORDS = 2;

    typedef logic [WORD_W-1:0] word_t;

    // hit count lands here at the end of a flush
    localparam word_t STATS_ADDR = 32'h00003100;

    typedef struct packed {
        logic [DTAG_W-1:0] tag;
        logic [DIDX_W-1:0] idx;
        logic [DBLK_W-1:0] blkoff;
        logic [DBYT_W-1:0] bytoff;
    } dcachef_t;

    // one way's entry at one index
    typedef struct packed {
        logic                         valid;
        logic                         dirty;
        logic [DTAG_W-1:0]            tag;
        word_t [DBLK_WORDS-1:0]       data;
    } dcache_frame;

endpackage

`default_nettype wire
